/* tb/mul_exec_input.txt */
// kind 1 issue: f3 target src1 val1 tag1 src2 val2 tag2 join; src 0 rf 1 rob 2 wait 3 both
// kind 2 cdb: port tag data; 3 wait n results; 4 expect tag value; 5 full; 6 idle n; 7 absent tag; 0 end
6 8 0 0 0 0 0 0 0 0
5 0 0 0 0 0 0 0 0 0
1 0 0 0 FFFFFFFF 0 0 00000007 0 0
1 1 1 0 80000000 0 0 80000000 0 0
1 2 2 0 FFFFFFFF 0 0 FFFFFFFF 0 0
1 3 3 0 FFFFFFFF 0 0 FFFFFFFF 0 0
1 1 4 0 00000000 0 0 80000000 0 0
1 1 5 0 FFFFFFFE 0 0 00000003 0 0
1 2 6 0 80000000 0 0 80000000 0 0
3 7 0 0 0 0 0 0 0 0
4 0 FFFFFFF9 0 0 0 0 0 0 0
4 1 40000000 0 0 0 0 0 0 0
4 2 FFFFFFFF 0 0 0 0 0 0 0
4 3 FFFFFFFE 0 0 0 0 0 0 0
4 4 00000000 0 0 0 0 0 0 0
4 5 FFFFFFFF 0 0 0 0 0 0 0
4 6 C0000000 0 0 0 0 0 0 0
1 0 0 1 00000003 0 1 FFFFFFFB 0 0
1 3 1 3 00010000 0 3 00010000 0 0
1 0 2 0 00000100 0 1 00000200 0 0
3 3 0 0 0 0 0 0 0 0
4 0 FFFFFFF1 0 0 0 0 0 0 0
4 1 00000001 0 0 0 0 0 0 0
4 2 00020000 0 0 0 0 0 0 0
1 0 1 2 00000000 5 0 00000009 0 0
6 10 0 0 0 0 0 0 0 0
7 1 0 0 0 0 0 0 0 0
2 0 5 00000011 0 0 0 0 0 0
3 1 0 0 0 0 0 0 0 0
4 1 00000099 0 0 0 0 0 0 0
1 1 2 2 00000000 6 2 00000000 7 1
2 1 6 FFFFFFF0 0 0 0 0 0 0
2 0 3 00000055 0 0 0 0 0 0
6 30 0 0 0 0 0 0 0 0
7 2 0 0 0 0 0 0 0 0
2 1 7 10000000 0 0 0 0 0 0
3 1 0 0 0 0 0 0 0 0
4 2 FFFFFFFF 0 0 0 0 0 0 0
1 0 0 0 00000002 0 0 00000003 0 0
1 1 1 0 FFFFFFFF 0 0 FFFFFFFF 0 0
1 3 2 0 80000000 0 0 80000000 0 0
1 2 3 0 00000002 0 0 FFFFFFFF 0 0
1 0 4 0 80000000 0 0 FFFFFFFF 0 0
1 1 5 0 7FFFFFFF 0 0 7FFFFFFF 0 0
1 3 6 0 00000000 0 0 FFFFFFFF 0 0
1 2 7 0 FFFFFFFF 0 0 00000001 0 0
5 1 0 0 0 0 0 0 0 0
3 1 0 0 0 0 0 0 0 0
5 0 0 0 0 0 0 0 0 0
3 8 0 0 0 0 0 0 0 0
4 0 00000006 0 0 0 0 0 0 0
4 1 00000000 0 0 0 0 0 0 0
4 2 40000000 0 0 0 0 0 0 0
4 3 00000001 0 0 0 0 0 0 0
4 4 80000000 0 0 0 0 0 0 0
4 5 3FFFFFFF 0 0 0 0 0 0 0
4 6 00000000 0 0 0 0 0 0 0
4 7 FFFFFFFF 0 0 0 0 0 0 0
0 0 0 0 0 0 0 0 0 0

/* verilog.f */
common/rv32m_pkg.sv
common/ooo_pkg.sv
mul_unit/shift_add_multiplier.sv
mul_unit/mul_rs.sv
hw/mul_exec_top.sv
tb/tb_mul_exec.sv

/* Makefile */
TOP := tb_mul_exec

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --timescale 1ns/1ps -f verilog.f \
	  --top-module $(TOP) --Mdir obj_dir -o sim

run: compile
	./obj_dir/sim | tee run.log
	grep -q "^PASS: all tests$$" run.log

clean:
	rm -rf obj_dir run.log

/* tb/tb_mul_exec.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_mul_exec;

  localparam int fields = 10;
  localparam int max_records = 128;
  localparam int tag_count = 1 << ooo_pkg::rob_tag_bits;
  // longer than issue to result, so a wrongly woken entry shows up before the check
  localparam int absent_window = ooo_pkg::mul_latency + 4;

  logic clk = 1'b0;
  logic rst;
  logic issue;
  rv32m_pkg::opcode_t opcode;
  rv32m_pkg::funct3_t funct3;
  rv32m_pkg::funct7_t funct7;
  ooo_pkg::rob_tag_t target_rob;
  logic rs1_regfile_ready;
  logic rs2_regfile_ready;
  rv32m_pkg::word_t rs1_regfile_v;
  rv32m_pkg::word_t rs2_regfile_v;
  ooo_pkg::rob_tag_t rs1_regfile_rob;
  ooo_pkg::rob_tag_t rs2_regfile_rob;
  logic rs1_rob_ready;
  logic rs2_rob_ready;
  rv32m_pkg::word_t rs1_rob_v;
  rv32m_pkg::word_t rs2_rob_v;
  logic cdb_valid [ooo_pkg::cdb_ports];
  ooo_pkg::rob_tag_t cdb_rob [ooo_pkg::cdb_ports];
  rv32m_pkg::word_t cdb_data [ooo_pkg::cdb_ports];
  logic full;
  logic result_valid;
  rv32m_pkg::word_t result_data;
  ooo_pkg::rob_tag_t result_rob;

  // stimulus records of fields words each
  logic [31:0] stim [fields * max_records];

  // per-tag counts of results seen on the bus and results already checked
  int arrivals [tag_count] = '{default: 0};
  int consumed [tag_count];
  rv32m_pkg::word_t got_data [tag_count];
  int monitor_errors = 0;
  int value_errors;
  int other_errors;
  logic aborted;

  mul_exec_top mul_exec_top_inst (
    .clk               (clk),
    .rst               (rst),
    .issue             (issue),
    .opcode            (opcode),
    .funct3            (funct3),
    .funct7            (funct7),
    .target_rob        (target_rob),
    .rs1_regfile_ready (rs1_regfile_ready),
    .rs2_regfile_ready (rs2_regfile_ready),
    .rs1_regfile_v     (rs1_regfile_v),
    .rs2_regfile_v     (rs2_regfile_v),
    .rs1_regfile_rob   (rs1_regfile_rob),
    .rs2_regfile_rob   (rs2_regfile_rob),
    .rs1_rob_ready     (rs1_rob_ready),
    .rs2_rob_ready     (rs2_rob_ready),
    .rs1_rob_v         (rs1_rob_v),
    .rs2_rob_v         (rs2_rob_v),
    .cdb_valid         (cdb_valid),
    .cdb_rob           (cdb_rob),
    .cdb_data          (cdb_data),
    .full              (full),
    .result_valid      (result_valid),
    .result_data       (result_data),
    .result_rob        (result_rob)
  );

  always #5 clk = ~clk;

  // results are sampled mid-cycle and kept by tag
  always @(negedge clk) begin
    if (!rst && result_valid) begin
      if (arrivals[result_rob] != consumed[result_rob]) begin
        $display("Error: tag %0d returned a second result before the first was checked",
                 result_rob);
        monitor_errors++;
      end
      got_data[result_rob] = result_data;
      arrivals[result_rob]++;
    end
  end

  function automatic int pending();
    int n;
    n = 0;
    for (int t = 0; t < tag_count; t++) begin
      n += arrivals[t] - consumed[t];
    end
    return n;
  endfunction

  task automatic clear_strobes();
    issue <= 1'b0;
    for (int j = 0; j < ooo_pkg::cdb_ports; j++) begin
      cdb_valid[j] <= 1'b0;
    end
  endtask

  // source codes 0 regfile, 1 ROB, 2 wait on tag, 3 both ready
  // the side that must not be used gets the inverted value
  task automatic drive_issue(input int b);
    logic [31:0] src1;
    logic [31:0] src2;
    src1 = stim[b + 3];
    src2 = stim[b + 6];
    issue <= 1'b1;
    opcode <= rv32m_pkg::opcode_op;
    funct7 <= rv32m_pkg::funct7_muldiv;
    funct3 <= rv32m_pkg::funct3_t'(stim[b + 1]);
    target_rob <= ooo_pkg::rob_tag_t'(stim[b + 2]);
    rs1_regfile_ready <= (src1 == 32'd0) || (src1 == 32'd3);
    rs1_rob_ready <= (src1 == 32'd1) || (src1 == 32'd3);
    rs1_regfile_v <= (src1 == 32'd1) ? ~stim[b + 4] : stim[b + 4];
    rs1_rob_v <= (src1 == 32'd1) ? stim[b + 4] : ~stim[b + 4];
    rs1_regfile_rob <= ooo_pkg::rob_tag_t'(stim[b + 5]);
    rs2_regfile_ready <= (src2 == 32'd0) || (src2 == 32'd3);
    rs2_rob_ready <= (src2 == 32'd1) || (src2 == 32'd3);
    rs2_regfile_v <= (src2 == 32'd1) ? ~stim[b + 7] : stim[b + 7];
    rs2_rob_v <= (src2 == 32'd1) ? stim[b + 7] : ~stim[b + 7];
    rs2_regfile_rob <= ooo_pkg::rob_tag_t'(stim[b + 8]);
  endtask

  task automatic drive_cdb(input int b);
    int port;
    port = int'(stim[b + 1]);
    if (port >= 0 && port < ooo_pkg::cdb_ports) begin
      cdb_valid[port] <= 1'b1;
      cdb_rob[port] <= ooo_pkg::rob_tag_t'(stim[b + 2]);
      cdb_data[port] <= stim[b + 3];
    end else begin
      $display("Error: a record names CDB port %0d, which does not exist", port);
      other_errors++;
    end
  endtask

  task automatic drive_record(input int b);
    if (stim[b] == 32'd1) begin
      drive_issue(b);
    end else if (stim[b] == 32'd2) begin
      drive_cdb(b);
    end else begin
      $display("Error: record kind %0d cannot be joined into a drive cycle", stim[b]);
      other_errors++;
    end
  endtask

  task automatic wait_results(input int n);
    int cycles;
    cycles = 0;
    do begin
      @(posedge clk);
      clear_strobes();
      cycles++;
    end while (pending() < n && cycles < n * 50 + 20);
    if (pending() < n) begin
      $display("Error: timed out waiting for %0d results, only %0d arrived", n, pending());
      other_errors++;
      aborted = 1'b1;
    end
  endtask

  task automatic check_result(input ooo_pkg::rob_tag_t tag, input rv32m_pkg::word_t expected);
    if (arrivals[tag] == consumed[tag]) begin
      $display("Error: no result came back for tag %0d", tag);
      other_errors++;
    end else begin
      if (got_data[tag] !== expected) begin
        $display("Fail: result_data for tag %0d got 0x%h expected 0x%h",
                 tag, got_data[tag], expected);
        value_errors++;
      end
      consumed[tag]++;
    end
  endtask

  task automatic check_flag(input logic expected);
    if (full !== expected) begin
      $display("Fail: full got 0x%h expected 0x%h", full, expected);
      value_errors++;
    end
  endtask

  task automatic check_absent(input ooo_pkg::rob_tag_t tag);
    repeat (absent_window) begin
      @(posedge clk);
      clear_strobes();
    end
    if (arrivals[tag] != consumed[tag]) begin
      $display("Error: tag %0d returned a result while its operands were still missing", tag);
      other_errors++;
    end
  endtask

  initial begin : main
    int rec;
    int b;
    int n;
    rst = 1'b1;
    issue = 1'b0;
    opcode = rv32m_pkg::opcode_op;
    funct3 = '0;
    funct7 = rv32m_pkg::funct7_muldiv;
    target_rob = '0;
    rs1_regfile_ready = 1'b0;
    rs2_regfile_ready = 1'b0;
    rs1_regfile_v = '0;
    rs2_regfile_v = '0;
    rs1_regfile_rob = '0;
    rs2_regfile_rob = '0;
    rs1_rob_ready = 1'b0;
    rs2_rob_ready = 1'b0;
    rs1_rob_v = '0;
    rs2_rob_v = '0;
    for (int j = 0; j < ooo_pkg::cdb_ports; j++) begin
      cdb_valid[j] = 1'b0;
      cdb_rob[j] = '0;
      cdb_data[j] = '0;
    end
    for (int t = 0; t < tag_count; t++) begin
      consumed[t] = 0;
    end
    value_errors = 0;
    other_errors = 0;
    aborted = 1'b0;
    $readmemh("tb/mul_exec_input.txt", stim);

    repeat (3) @(posedge clk);
    rst <= 1'b0;

    rec = 0;
    while (!aborted && rec < max_records) begin
      b = rec * fields;
      if ($isunknown(stim[b]) || stim[b] == 32'd0) begin
        break;
      end
      case (stim[b])
        32'd1, 32'd2: begin
          @(posedge clk);
          clear_strobes();
          drive_record(b);
          // joined records go out in the same cycle
          while (stim[b + 9] == 32'd1 && rec + 1 < max_records) begin
            rec++;
            b = rec * fields;
            drive_record(b);
          end
        end
        32'd3: wait_results(int'(stim[b + 1]));
        32'd4: check_result(ooo_pkg::rob_tag_t'(stim[b + 1]), stim[b + 2]);
        32'd5: begin
          @(posedge clk);
          clear_strobes();
          @(negedge clk);
          check_flag(stim[b + 1][0]);
        end
        32'd6: begin
          n = int'(stim[b + 1]);
          repeat (n) begin
            @(posedge clk);
            clear_strobes();
          end
        end
        32'd7: check_absent(ooo_pkg::rob_tag_t'(stim[b + 1]));
        default: begin
          $display("Error: unknown record kind %0d at record %0d", stim[b], rec);
          other_errors++;
          aborted = 1'b1;
        end
      endcase
      rec++;
    end

    for (int t = 0; t < tag_count; t++) begin
      if (arrivals[t] != consumed[t]) begin
        $display("Error: tag %0d returned a result that no record expected", t);
        other_errors++;
      end
    end

    $display("errors: %0d value, %0d monitor, %0d other",
             value_errors, monitor_errors, other_errors);
    if (value_errors + monitor_errors + other_errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* hw/mul_exec_top.sv */
`timescale 1ns/1ps
`default_nettype none

module mul_exec_top (
  input  logic                clk,
  input  logic                rst,
  input  logic                issue,
  input  rv32m_pkg::opcode_t  opcode,
  input  rv32m_pkg::funct3_t  funct3,
  input  rv32m_pkg::funct7_t  funct7,
  input  ooo_pkg::rob_tag_t   target_rob,
  input  logic                rs1_regfile_ready,
  input  logic                rs2_regfile_ready,
  input  rv32m_pkg::word_t    rs1_regfile_v,
  input  rv32m_pkg::word_t    rs2_regfile_v,
  input  ooo_pkg::rob_tag_t   rs1_regfile_rob,
  input  ooo_pkg::rob_tag_t   rs2_regfile_rob,
  input  logic                rs1_rob_ready,
  input  logic                rs2_rob_ready,
  input  rv32m_pkg::word_t    rs1_rob_v,
  input  rv32m_pkg::word_t    rs2_rob_v,
  input  logic                cdb_valid [ooo_pkg::cdb_ports],
  input  ooo_pkg::rob_tag_t   cdb_rob   [ooo_pkg::cdb_ports],
  input  rv32m_pkg::word_t    cdb_data  [ooo_pkg::cdb_ports],
  output logic                full,
  output logic                result_valid,
  output rv32m_pkg::word_t    result_data,
  output ooo_pkg::rob_tag_t   result_rob
);

  // station to multiplier
  logic mul_start;
  logic mul_busy;
  logic mul_done;
  rv32m_pkg::word_t mul_a;
  rv32m_pkg::word_t mul_b;
  rv32m_pkg::mul_mode_t mul_mode;
  rv32m_pkg::product_t mul_p;

  mul_rs mul_rs_inst (
    .clk               (clk),
    .rst               (rst),
    .issue             (issue),
    .opcode            (opcode),
    .funct3            (funct3),
    .funct7            (funct7),
    .target_rob        (target_rob),
    .rs1_regfile_ready (rs1_regfile_ready),
    .rs2_regfile_ready (rs2_regfile_ready),
    .rs1_regfile_v     (rs1_regfile_v),
    .rs2_regfile_v     (rs2_regfile_v),
    .rs1_regfile_rob   (rs1_regfile_rob),
    .rs2_regfile_rob   (rs2_regfile_rob),
    .rs1_rob_ready     (rs1_rob_ready),
    .rs2_rob_ready     (rs2_rob_ready),
    .rs1_rob_v         (rs1_rob_v),
    .rs2_rob_v         (rs2_rob_v),
    .cdb_valid         (cdb_valid),
    .cdb_rob           (cdb_rob),
    .cdb_data          (cdb_data),
    .mul_busy          (mul_busy),
    .mul_done          (mul_done),
    .mul_p             (mul_p),
    .full              (full),
    .mul_start         (mul_start),
    .mul_a             (mul_a),
    .mul_b             (mul_b),
    .mul_mode          (mul_mode),
    .result_valid      (result_valid),
    .result_data       (result_data),
    .result_rob        (result_rob)
  );

  shift_add_multiplier shift_add_multiplier_inst (
    .clk   (clk),
    .rst   (rst),
    .start (mul_start),
    .mode  (mul_mode),
    .a     (mul_a),
    .b     (mul_b),
    .busy  (mul_busy),
    .done  (mul_done),
    .p     (mul_p)
  );

endmodule

`default_nettype wire

/* mul_unit/mul_rs.sv */
`timescale 1ns/1ps
`default_nettype none

module mul_rs (
  input  logic                 clk,
  input  logic                 rst,
  // issue stage
  input  logic                 issue,
  input  rv32m_pkg::opcode_t   opcode,
  input  rv32m_pkg::funct3_t   funct3,
  input  rv32m_pkg::funct7_t   funct7,
  input  ooo_pkg::rob_tag_t    target_rob,
  // regfile with scoreboard tag
  input  logic                 rs1_regfile_ready,
  input  logic                 rs2_regfile_ready,
  input  rv32m_pkg::word_t     rs1_regfile_v,
  input  rv32m_pkg::word_t     rs2_regfile_v,
  input  ooo_pkg::rob_tag_t    rs1_regfile_rob,
  input  ooo_pkg::rob_tag_t    rs2_regfile_rob,
  // reorder buffer
  input  logic                 rs1_rob_ready,
  input  logic                 rs2_rob_ready,
  input  rv32m_pkg::word_t     rs1_rob_v,
  input  rv32m_pkg::word_t     rs2_rob_v,
  // snooped result buses
  input  logic                 cdb_valid [ooo_pkg::cdb_ports],
  input  ooo_pkg::rob_tag_t    cdb_rob   [ooo_pkg::cdb_ports],
  input  rv32m_pkg::word_t     cdb_data  [ooo_pkg::cdb_ports],
  // multiplier
  input  logic                 mul_busy,
  input  logic                 mul_done,
  input  rv32m_pkg::product_t  mul_p,
  output logic                 full,
  output logic                 mul_start,
  output rv32m_pkg::word_t     mul_a,
  output rv32m_pkg::word_t     mul_b,
  output rv32m_pkg::mul_mode_t mul_mode,
  // own result bus
  output logic                 result_valid,
  output rv32m_pkg::word_t     result_data,
  output ooo_pkg::rob_tag_t    result_rob
);

  localparam int depth = ooo_pkg::rs_depth;

  // per-entry state
  logic entry_busy [depth];
  logic rs1_rdy [depth];
  logic rs2_rdy [depth];
  rv32m_pkg::funct3_t entry_funct3 [depth];
  rv32m_pkg::word_t rs1_v [depth];
  rv32m_pkg::word_t rs2_v [depth];
  ooo_pkg::rob_tag_t rs1_tag [depth];
  ooo_pkg::rob_tag_t rs2_tag [depth];
  ooo_pkg::rob_tag_t target_tag [depth];

  // entry currently on the multiplier
  logic executing;
  ooo_pkg::rs_index_t exec_idx;

  logic rs1_wake [depth];
  logic rs2_wake [depth];
  logic free_found;
  ooo_pkg::rs_index_t free_idx;
  logic alloc;
  logic pick_found;
  ooo_pkg::rs_index_t pick_idx;
  logic pick_go;

  logic new_rs1_rdy;
  logic new_rs2_rdy;
  rv32m_pkg::word_t new_rs1_v;
  rv32m_pkg::word_t new_rs2_v;

  function automatic logic cdb_hit(input ooo_pkg::rob_tag_t tag);
    logic hit;
    hit = 1'b0;
    for (int j = 0; j < ooo_pkg::cdb_ports; j++) begin
      if (cdb_valid[j] && cdb_rob[j] == tag) begin
        hit = 1'b1;
      end
    end
    return hit;
  endfunction

  function automatic rv32m_pkg::word_t cdb_value(input ooo_pkg::rob_tag_t tag);
    rv32m_pkg::word_t value;
    value = '0;
    for (int j = 0; j < ooo_pkg::cdb_ports; j++) begin
      if (cdb_valid[j] && cdb_rob[j] == tag) begin
        value = cdb_data[j];
      end
    end
    return value;
  endfunction

  // MUL takes the low word, so any mode works there
  function automatic rv32m_pkg::mul_mode_t mode_of(input rv32m_pkg::funct3_t f3);
    case (f3)
      rv32m_pkg::funct3_mulh:   return rv32m_pkg::mode_ss;
      rv32m_pkg::funct3_mulhsu: return rv32m_pkg::mode_su;
      default:                  return rv32m_pkg::mode_uu;
    endcase
  endfunction

  // at issue the regfile wins over the ROB and both win over a broadcast in this cycle
  always_comb begin
    new_rs1_rdy = 1'b1;
    if (rs1_regfile_ready) begin
      new_rs1_v = rs1_regfile_v;
    end else if (rs1_rob_ready) begin
      new_rs1_v = rs1_rob_v;
    end else begin
      new_rs1_rdy = cdb_hit(rs1_regfile_rob);
      new_rs1_v = cdb_value(rs1_regfile_rob);
    end
    new_rs2_rdy = 1'b1;
    if (rs2_regfile_ready) begin
      new_rs2_v = rs2_regfile_v;
    end else if (rs2_rob_ready) begin
      new_rs2_v = rs2_rob_v;
    end else begin
      new_rs2_rdy = cdb_hit(rs2_regfile_rob);
      new_rs2_v = cdb_value(rs2_regfile_rob);
    end
  end

  // waiting operands woken by the CDB
  always_comb begin
    for (int i = 0; i < depth; i++) begin
      rs1_wake[i] = entry_busy[i] && !rs1_rdy[i] && cdb_hit(rs1_tag[i]);
      rs2_wake[i] = entry_busy[i] && !rs2_rdy[i] && cdb_hit(rs2_tag[i]);
    end
  end

  // scanning from the top down leaves the lowest free and lowest ready entry
  always_comb begin
    free_found = 1'b0;
    free_idx = '0;
    pick_found = 1'b0;
    pick_idx = '0;
    for (int i = depth - 1; i >= 0; i--) begin
      if (!entry_busy[i]) begin
        free_found = 1'b1;
        free_idx = ooo_pkg::rs_index_t'(i);
      end
      if (entry_busy[i] && rs1_rdy[i] && rs2_rdy[i]) begin
        pick_found = 1'b1;
        pick_idx = ooo_pkg::rs_index_t'(i);
      end
    end
  end

  assign full = !free_found;
  assign alloc = issue && free_found;
  assign pick_go = pick_found && !executing && !mul_busy;

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < depth; i++) begin
        entry_busy[i] <= 1'b0;
        rs1_rdy[i] <= 1'b0;
        rs2_rdy[i] <= 1'b0;
      end
      executing <= 1'b0;
      mul_start <= 1'b0;
    end else begin
      mul_start <= pick_go;
      for (int i = 0; i < depth; i++) begin
        if (rs1_wake[i]) begin
          rs1_rdy[i] <= 1'b1;
        end
        if (rs2_wake[i]) begin
          rs2_rdy[i] <= 1'b1;
        end
      end
      if (alloc) begin
        entry_busy[free_idx] <= 1'b1;
        rs1_rdy[free_idx] <= new_rs1_rdy;
        rs2_rdy[free_idx] <= new_rs2_rdy;
      end
      if (pick_go) begin
        executing <= 1'b1;
      end
      // result leaves on the CDB this cycle, so the entry frees now
      if (mul_done) begin
        executing <= 1'b0;
        entry_busy[exec_idx] <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    for (int i = 0; i < depth; i++) begin
      if (rs1_wake[i]) begin
        rs1_v[i] <= cdb_value(rs1_tag[i]);
      end
      if (rs2_wake[i]) begin
        rs2_v[i] <= cdb_value(rs2_tag[i]);
      end
    end
    if (alloc) begin
      entry_funct3[free_idx] <= funct3;
      rs1_v[free_idx] <= new_rs1_v;
      rs2_v[free_idx] <= new_rs2_v;
      rs1_tag[free_idx] <= rs1_regfile_rob;
      rs2_tag[free_idx] <= rs2_regfile_rob;
      target_tag[free_idx] <= target_rob;
    end
    if (pick_go) begin
      exec_idx <= pick_idx;
      mul_a <= rs1_v[pick_idx];
      mul_b <= rs2_v[pick_idx];
      mul_mode <= mode_of(entry_funct3[pick_idx]);
    end
  end

  // result formatting uses the executing entry's own funct3
  assign result_valid = mul_done;
  assign result_data = (entry_funct3[exec_idx] == rv32m_pkg::funct3_mul) ?
                       mul_p[31:0] : mul_p[63:32];
  assign result_rob = target_tag[exec_idx];

  a_no_issue_when_full: assert property (
    @(posedge clk) disable iff (rst) issue |-> !full
  );

  a_done_only_when_executing: assert property (
    @(posedge clk) disable iff (rst) mul_done |-> executing
  );

  a_issue_is_multiply: assert property (
    @(posedge clk) disable iff (rst)
      issue |-> (opcode == rv32m_pkg::opcode_op && funct7 == rv32m_pkg::funct7_muldiv)
  );

endmodule

`default_nettype wire

/* mul_unit/shift_add_multiplier.sv */
`timescale 1ns/1ps
`default_nettype none

module shift_add_multiplier (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 start,
  input  rv32m_pkg::mul_mode_t mode,
  input  rv32m_pkg::word_t     a,
  input  rv32m_pkg::word_t     b,
  output logic                 busy,
  output logic                 done,
  output rv32m_pkg::product_t  p
);

  typedef enum logic [1:0] {
    st_idle,
    st_shift,
    st_fixup
  } state_t;

  localparam int count_bits = $clog2(ooo_pkg::mul_latency);

  state_t state;
  logic [count_bits-1:0] count;

  // unsigned multiplicand and running {partial sum, multiplier} register
  rv32m_pkg::word_t mcand;
  rv32m_pkg::product_t acc;
  logic neg;

  logic a_neg;
  logic b_neg;
  rv32m_pkg::word_t a_mag;
  rv32m_pkg::word_t b_mag;
  logic [32:0] sum;
  rv32m_pkg::product_t step;

  // magnitudes go into the datapath and the signs decide the fixup
  always_comb begin
    a_neg = (mode != rv32m_pkg::mode_uu) && a[31];
    b_neg = (mode == rv32m_pkg::mode_ss) && b[31];
    a_mag = a_neg ? -a : a;
    b_mag = b_neg ? -b : b;
  end

  // each iteration adds the multiplicand on a set multiplier bit and shifts right
  always_comb begin
    sum = {1'b0, acc[63:32]} + (acc[0] ? {1'b0, mcand} : 33'd0);
    step = {sum, acc[31:1]};
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= st_idle;
      count <= '0;
    end else begin
      case (state)
        st_idle: begin
          if (start) begin
            state <= st_shift;
            count <= '0;
          end
        end
        st_shift: begin
          if (count == count_bits'(ooo_pkg::mul_latency - 1)) begin
            state <= st_fixup;
          end
          count <= count + 1'b1;
        end
        st_fixup: begin
          state <= st_idle;
        end
        default: begin
          state <= st_idle;
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == st_idle && start) begin
      mcand <= a_mag;
      acc <= {32'd0, b_mag};
      neg <= a_neg ^ b_neg;
    end else if (state == st_shift) begin
      acc <= step;
    end
  end

  // acc and neg stay put after fixup, so p holds until the next start
  assign p = neg ? -acc : acc;
  assign done = (state == st_fixup);
  assign busy = (state != st_idle);

  a_no_start_while_busy: assert property (
    @(posedge clk) disable iff (rst) start |-> !busy
  );

endmodule

`default_nettype wire

/* common/ooo_pkg.sv */
`default_nettype none

package ooo_pkg;

  // reorder buffer tag
  localparam int rob_tag_bits = 3;
  typedef logic [rob_tag_bits-1:0] rob_tag_t;

  // multiply reservation station
  localparam int rs_index_bits = 3;
  localparam int rs_depth = 1 << rs_index_bits;
  typedef logic [rs_index_bits-1:0] rs_index_t;

  // number of result buses the station listens to
  localparam int cdb_ports = 2;

  // one shift-add iteration per multiplier bit
  localparam int mul_latency = 32;

endpackage

`default_nettype wire

/* common/rv32m_pkg.sv */
`default_nettype none

package rv32m_pkg;

  // data widths seen by the multiply path
  typedef logic [31:0] word_t;
  typedef logic [63:0] product_t;

  // instruction fields
  typedef logic [6:0] opcode_t;
  typedef logic [6:0] funct7_t;
  typedef logic [2:0] funct3_t;

  // register-register major opcode that the base ALU ops share
  localparam opcode_t opcode_op = 7'b0110011;

  // funct7 that selects the M extension inside OP
  localparam funct7_t funct7_muldiv = 7'b0000001;

  // multiply variants of the M extension
  localparam funct3_t funct3_mul    = 3'b000;
  localparam funct3_t funct3_mulh   = 3'b001;
  localparam funct3_t funct3_mulhsu = 3'b010;
  localparam funct3_t funct3_mulhu  = 3'b011;

  // operand signedness seen by the multiplier
  // mode_su treats a as signed and b as unsigned
  typedef enum logic [1:0] {
    mode_uu,
    mode_ss,
    mode_su
  } mul_mode_t;

endpackage

`default_nettype wire
